/* src.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
int_core.sv
tb_core.sv

/* run.sh */
#!/usr/bin/env bash
# build tb_core with Verilator, run it, and look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_core -f src.f || { echo "build failed"; exit 1; }
./obj_dir/Vtb_core > sim.log 2>&1 || echo "simulator exited with an error"
[ -f sim.log ] || { echo "no simulation log"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

/* tb_core.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module tb_core;
   import isa_pkg::*;

   localparam int N_RANDOM      = 300;
   localparam int N_AFTER_HALT  = 20;
   localparam int N_AFTER_RESET = 40;
   // random instructions plus two stop instructions, each with a blocked write behind it
   localparam int N_ISSUED      = N_RANDOM + N_AFTER_HALT + N_AFTER_RESET + 4;
   localparam int CYCLE_LIMIT   = 4 * N_ISSUED + 200;
   // halted is due two cycles after the stop instruction is accepted
   localparam int HALT_WAIT     = 8;

   logic             clk;
   logic             rst_b;
   logic             inst_valid;
   logic [`XLEN-1:0] inst;
   logic             wb_valid;
   reg_addr_t        wb_addr;
   logic [`XLEN-1:0] wb_data;
   logic             halted;
   logic             halt_illegal;

   // xorshift state
   logic [31:0]      rng;
   int               cycle_cnt;
   // architectural register model
   logic [`XLEN-1:0] model_regs [`REG_COUNT];
   logic             model_stopped;
   // expected write-backs in issue order
   reg_addr_t        exp_addr [$];
   logic [`XLEN-1:0] exp_data [$];
   string            exp_name [$];
   string            phase;

   int_core dut_i (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_valid   (inst_valid),
      .inst         (inst),
      .wb_valid     (wb_valid),
      .wb_addr      (wb_addr),
      .wb_data      (wb_data),
      .halted       (halted),
      .halt_illegal (halt_illegal)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng = xorshift32(rng);
      r   = rng;
   endtask

   function automatic logic [31:0] encode_r(input funct_t fn, input reg_addr_t rs,
                                            input reg_addr_t rt, input reg_addr_t rd,
                                            input shamt_t sa);
      return {OP_SPECIAL, rs, rt, rd, sa, fn};
   endfunction

   function automatic logic [31:0] encode_i(input opcode_t op, input reg_addr_t rs,
                                            input reg_addr_t rt, input imm16_t imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] widen_addr(input reg_addr_t a);
      return {{(32-`REG_ADDR_W){1'b0}}, a};
   endfunction

   function automatic string mnemonic(input int kind);
      case (kind)
         0:       return "add";
         1:       return "addu";
         2:       return "sub";
         3:       return "subu";
         4:       return "and";
         5:       return "or";
         6:       return "xor";
         7:       return "addi";
         8:       return "addiu";
         9:       return "andi";
         10:      return "ori";
         11:      return "xori";
         12:      return "sll";
         13:      return "srl";
         default: return "sra";
      endcase
   endfunction

   task automatic fail_with(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1, "stopping on first error");
   endtask

   task automatic report_mismatch(input string name, input string field,
                                  input logic [31:0] expv, input logic [31:0] actv);
      $display("MISMATCH test=%s field=%s expected=0x%08h actual=0x%08h",
               name, field, expv, actv);
      $display("TB FAILED");
      $fatal(1, "stopping on first mismatch");
   endtask

   task automatic clear_model();
      for (int i = 0; i < `REG_COUNT; i++) begin
         model_regs[i] = '0;
      end
      model_stopped = 1'b0;
   endtask

   // r0 never changes, and nothing is expected once the core is stopping
   task automatic record_result(input string mnem, input reg_addr_t dest,
                                input logic [`XLEN-1:0] value);
      if (!model_stopped && (dest != '0)) begin
         model_regs[dest] = value;
         exp_addr.push_back(dest);
         exp_data.push_back(value);
         exp_name.push_back({phase, "/", mnem});
      end
   endtask

   task automatic send_inst(input logic [31:0] word);
      @(posedge clk);
      inst_valid <= 1'b1;
      inst       <= word;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         inst_valid <= 1'b0;
      end
   endtask

   // one random ALU instruction on r0..r7, sometimes after an idle cycle
   task automatic issue_random();
      logic [31:0]      ra;
      logic [31:0]      rb;
      reg_addr_t        rs;
      reg_addr_t        rt;
      reg_addr_t        rd;
      reg_addr_t        dest;
      shamt_t           sa;
      imm16_t           imm;
      logic [`XLEN-1:0] a;
      logic [`XLEN-1:0] b;
      logic [`XLEN-1:0] sx;
      logic [`XLEN-1:0] zx;
      logic [`XLEN-1:0] res;
      logic [31:0]      word;
      int               kind;
      next_rand(ra);
      next_rand(rb);
      if (ra[31:30] == 2'b00) begin
         idle_cycles(1);
      end
      rs   = {2'b00, ra[2:0]};
      rt   = {2'b00, ra[5:3]};
      rd   = {2'b00, ra[8:6]};
      sa   = ra[13:9];
      imm  = rb[15:0];
      kind = int'(rb[31:16] % 16'd15);
      a    = model_regs[rs];
      b    = model_regs[rt];
      // sign extension for addi/addiu, zero extension for logic immediates
      sx   = {{16{imm[15]}}, imm};
      zx   = {16'h0000, imm};
      dest = rd;
      // shifts move rt by shamt with the rs field left at zero
      case (kind)
         0:       word = encode_r(FN_ADD, rs, rt, rd, 5'd0);
         1:       word = encode_r(FN_ADDU, rs, rt, rd, 5'd0);
         2:       word = encode_r(FN_SUB, rs, rt, rd, 5'd0);
         3:       word = encode_r(FN_SUBU, rs, rt, rd, 5'd0);
         4:       word = encode_r(FN_AND, rs, rt, rd, 5'd0);
         5:       word = encode_r(FN_OR, rs, rt, rd, 5'd0);
         6:       word = encode_r(FN_XOR, rs, rt, rd, 5'd0);
         7:       word = encode_i(OP_ADDI, rs, rt, imm);
         8:       word = encode_i(OP_ADDIU, rs, rt, imm);
         9:       word = encode_i(OP_ANDI, rs, rt, imm);
         10:      word = encode_i(OP_ORI, rs, rt, imm);
         11:      word = encode_i(OP_XORI, rs, rt, imm);
         12:      word = encode_r(FN_SLL, 5'd0, rt, rd, sa);
         13:      word = encode_r(FN_SRL, 5'd0, rt, rd, sa);
         default: word = encode_r(FN_SRA, 5'd0, rt, rd, sa);
      endcase
      // 32-bit wraparound for signed and unsigned forms alike
      case (kind)
         0, 1:    res = a + b;
         2, 3:    res = a - b;
         4:       res = a & b;
         5:       res = a | b;
         6:       res = a ^ b;
         7, 8:    res = a + sx;
         9:       res = a & zx;
         10:      res = a | zx;
         11:      res = a ^ zx;
         12:      res = b << sa;
         13:      res = b >> sa;
         default: res = $signed(b) >>> sa;
      endcase
      // immediate forms write rt
      if ((kind >= 7) && (kind <= 11)) begin
         dest = rt;
      end
      send_inst(word);
      record_result(mnemonic(kind), dest, res);
   endtask

   // a syscall or reserved instruction blocks the write issued right behind it
   task automatic issue_stop(input logic [31:0] word);
      send_inst(word);
      model_stopped = 1'b1;
      send_inst(encode_i(OP_ORI, 5'd0, 5'd1, 16'h00ff));
      idle_cycles(1);
   endtask

   task automatic apply_reset();
      rst_b      <= 1'b0;
      inst_valid <= 1'b0;
      repeat (10) @(posedge clk);
      rst_b <= 1'b1;
   endtask

   task automatic check_idle();
      @(negedge clk);
      assert (!wb_valid && !halted && !halt_illegal) else
         fail_with("outputs are not idle after reset");
   endtask

   task automatic wait_for_halt();
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!halted && (waited < HALT_WAIT));
      assert (halted) else
         fail_with("halted did not rise after the stop instruction");
   endtask

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      assert (cycle_cnt < CYCLE_LIMIT) else
         fail_with("timeout, the run took more cycles than the limit");
   end

   // write-backs are sampled mid-cycle when the outputs have settled
   always @(negedge clk) begin
      if (rst_b && wb_valid) begin
         assert (exp_addr.size() > 0) else
            fail_with($sformatf("write-back to r%0d when none was expected", wb_addr));
         assert (wb_addr == exp_addr[0]) else
            report_mismatch(exp_name[0], "addr", widen_addr(exp_addr[0]), widen_addr(wb_addr));
         assert (wb_data == exp_data[0]) else
            report_mismatch(exp_name[0], "data", exp_data[0], wb_data);
         exp_addr.pop_front();
         exp_data.pop_front();
         exp_name.pop_front();
      end
   end

   initial begin
      clk        = 1'b0;
      rst_b      = 1'b0;
      inst_valid = 1'b0;
      inst       = '0;
      rng        = 32'd12061;
      cycle_cnt  = 0;
      phase      = "reset";
      clear_model();
      apply_reset();
      check_idle();

      // arithmetic, logic, immediates, shifts and dependencies
      phase = "random";
      repeat (N_RANDOM) issue_random();

      phase = "syscall";
      issue_stop(encode_r(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      wait_for_halt();
      assert (exp_addr.size() == 0) else
         fail_with("halted rose before all write-backs retired");
      assert (!halt_illegal) else
         fail_with("halt_illegal raised by a syscall");

      // the stopped core must not retire these
      phase = "after_halt";
      repeat (N_AFTER_HALT) issue_random();
      idle_cycles(8);
      @(negedge clk);
      assert (halted && !halt_illegal) else
         fail_with("halt state changed after the syscall");

      @(posedge clk);
      apply_reset();
      clear_model();
      check_idle();

      phase = "after_reset";
      repeat (N_AFTER_RESET) issue_random();

      phase = "reserved";
      issue_stop(encode_i(6'h3f, 5'd1, 5'd2, 16'h1234));
      wait_for_halt();
      assert (exp_addr.size() == 0) else
         fail_with("halted rose before all write-backs retired");
      assert (halt_illegal) else
         fail_with("reserved opcode did not raise halt_illegal");

      $display("TB PASSED");
      $finish;
   end

endmodule

/* int_core.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module int_core (
   input  logic                clk,
   input  logic                rst_b,
   input  logic                inst_valid,
   input  logic [`XLEN-1:0]    inst,
   output logic                wb_valid,
   output isa_pkg::reg_addr_t  wb_addr,
   output logic [`XLEN-1:0]    wb_data,
   output logic                halted,
   output logic                halt_illegal
);
   import isa_pkg::*;
   import pipe_pkg::*;

   // register file read side
   reg_addr_t        rd_rs_addr;
   reg_addr_t        rd_rt_addr;
   logic [`XLEN-1:0] rd_rs_data;
   logic [`XLEN-1:0] rd_rt_data;

   // decode to execute
   logic             dx_valid;
   alu_op_e          dx_alu_op;
   op_src_e          dx_src;
   reg_addr_t        dx_rs;
   reg_addr_t        dx_rt;
   logic [`XLEN-1:0] dx_rs_data;
   logic [`XLEN-1:0] dx_rt_data;
   logic [`XLEN-1:0] dx_imm;
   reg_addr_t        dx_dest;
   logic             dx_we;
   logic             dx_sys;
   logic             dx_ill;

   // execute to result, also the forwarding source
   logic             xr_valid;
   reg_addr_t        xr_dest;
   logic             xr_we;
   logic [`XLEN-1:0] xr_data;
   logic             xr_sys;
   logic             xr_ill;

   // register file write side
   logic             rf_we;
   reg_addr_t        rf_addr;
   logic [`XLEN-1:0] rf_data;

   // every port name matches the net of the same name above
   decode_stage decode_i (.*);

   execute_stage execute_i (.*);

   result_stage result_i (.*);

   reg_file reg_file_i (.*);

endmodule

/* result_stage.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module result_stage (
   input  logic                clk,
   input  logic                rst_b,
   input  logic                xr_valid,
   input  isa_pkg::reg_addr_t  xr_dest,
   input  logic                xr_we,
   input  logic [`XLEN-1:0]    xr_data,
   input  logic                xr_sys,
   input  logic                xr_ill,
   // register file write port
   output logic                rf_we,
   output isa_pkg::reg_addr_t  rf_addr,
   output logic [`XLEN-1:0]    rf_data,
   // retire trace
   output logic                wb_valid,
   output isa_pkg::reg_addr_t  wb_addr,
   output logic [`XLEN-1:0]    wb_data,
   output logic                halted,
   output logic                halt_illegal
);

   // writes to r0 are dropped here
   logic write;
   logic retire_sys;
   logic retire_ill;
   // sticky halt state
   logic halt_q;
   logic ill_q;

   assign write = xr_valid & xr_we & (xr_dest != '0);

   assign rf_we    = write;
   assign rf_addr  = xr_dest;
   assign rf_data  = xr_data;
   assign wb_valid = write;
   assign wb_addr  = xr_dest;
   assign wb_data  = xr_data;

   assign retire_sys = xr_valid & xr_sys;
   assign retire_ill = xr_valid & xr_ill;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halt_q <= 1'b0;
         ill_q  <= 1'b0;
      end else begin
         halt_q <= halt_q | retire_sys | retire_ill;
         ill_q  <= ill_q | retire_ill;
      end
   end

   // raised in the retire cycle itself, then held by the flops
   assign halted       = halt_q | retire_sys | retire_ill;
   assign halt_illegal = ill_q | retire_ill;

endmodule

/* execute_stage.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module execute_stage (
   input  logic                clk,
   input  logic                rst_b,
   input  logic                dx_valid,
   input  pipe_pkg::alu_op_e   dx_alu_op,
   input  pipe_pkg::op_src_e   dx_src,
   input  isa_pkg::reg_addr_t  dx_rs,
   input  isa_pkg::reg_addr_t  dx_rt,
   input  logic [`XLEN-1:0]    dx_rs_data,
   input  logic [`XLEN-1:0]    dx_rt_data,
   input  logic [`XLEN-1:0]    dx_imm,
   input  isa_pkg::reg_addr_t  dx_dest,
   input  logic                dx_we,
   input  logic                dx_sys,
   input  logic                dx_ill,
   output logic                xr_valid,
   output isa_pkg::reg_addr_t  xr_dest,
   output logic                xr_we,
   output logic [`XLEN-1:0]    xr_data,
   output logic                xr_sys,
   output logic                xr_ill
);
   import isa_pkg::*;
   import pipe_pkg::*;

   // operands after forwarding
   logic [`XLEN-1:0] rs_val;
   logic [`XLEN-1:0] rt_val;
   // second operand, rt or immediate
   logic [`XLEN-1:0] op_b;
   // shifts only look at the low bits
   shamt_t           sh;
   logic [`XLEN-1:0] alu_res;

   // take the result one ahead when it writes this source
   // r0 is never forwarded, the register file already returns zero
   function automatic logic [`XLEN-1:0] fwd(input reg_addr_t src_reg,
                                            input logic [`XLEN-1:0] rf_val);
      logic hit;
      hit = xr_valid && xr_we && (xr_dest != '0) && (xr_dest == src_reg);
      return hit ? xr_data : rf_val;
   endfunction

   always_comb begin
      rs_val = fwd(dx_rs, dx_rs_data);
      rt_val = fwd(dx_rt, dx_rt_data);
   end

   always_comb begin
      op_b = (dx_src == SRC_IMM) ? dx_imm : rt_val;
      sh   = op_b[$bits(shamt_t)-1:0];
      // no overflow trap, so signed and unsigned forms both wrap
      case (dx_alu_op)
         ALU_ADD, ALU_ADDU: alu_res = rs_val + op_b;
         ALU_SUB, ALU_SUBU: alu_res = rs_val - op_b;
         ALU_AND:           alu_res = rs_val & op_b;
         ALU_OR:            alu_res = rs_val | op_b;
         ALU_XOR:           alu_res = rs_val ^ op_b;
         // shifted value is rt, amount sits in the immediate
         ALU_SLL:           alu_res = rt_val << sh;
         ALU_SRL:           alu_res = rt_val >> sh;
         ALU_SRA:           alu_res = $signed(rt_val) >>> sh;
         default:           alu_res = '0;
      endcase
   end

   // execute-to-result register, control part
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         xr_valid <= 1'b0;
         xr_we    <= 1'b0;
         xr_sys   <= 1'b0;
         xr_ill   <= 1'b0;
      end else begin
         xr_valid <= dx_valid;
         xr_we    <= dx_valid & dx_we;
         xr_sys   <= dx_valid & dx_sys;
         xr_ill   <= dx_valid & dx_ill;
      end
   end

   // execute-to-result register, payload part
   always_ff @(posedge clk) begin
      xr_dest <= dx_dest;
      xr_data <= alu_res;
   end

endmodule

/* decode_stage.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module decode_stage (
   input  logic                clk,
   input  logic                rst_b,
   input  logic                inst_valid,
   input  logic [`XLEN-1:0]    inst,
   input  logic [`XLEN-1:0]    rd_rs_data,
   input  logic [`XLEN-1:0]    rd_rt_data,
   output isa_pkg::reg_addr_t  rd_rs_addr,
   output isa_pkg::reg_addr_t  rd_rt_addr,
   output logic                dx_valid,
   output pipe_pkg::alu_op_e   dx_alu_op,
   output pipe_pkg::op_src_e   dx_src,
   output isa_pkg::reg_addr_t  dx_rs,
   output isa_pkg::reg_addr_t  dx_rt,
   output logic [`XLEN-1:0]    dx_rs_data,
   output logic [`XLEN-1:0]    dx_rt_data,
   output logic [`XLEN-1:0]    dx_imm,
   output isa_pkg::reg_addr_t  dx_dest,
   output logic                dx_we,
   output logic                dx_sys,
   output logic                dx_ill
);
   import isa_pkg::*;
   import pipe_pkg::*;

   // instruction held from acceptance until it moves to execute
   logic             iq_valid;
   logic [`XLEN-1:0] iq_inst;
   // sticky once a syscall or reserved instruction is taken
   logic             stopped_q;
   logic             stop;
   logic             accept;

   // raw fields of the held instruction
   opcode_t          op;
   funct_t           funct;
   reg_addr_t        rs;
   reg_addr_t        rt;
   reg_addr_t        rd;
   shamt_t           shamt;
   imm16_t           imm;

   // decoded controls
   alu_op_e          alu_op;
   op_src_e          src;
   imm_kind_e        imm_kind;
   reg_addr_t        dest;
   logic             we;
   logic             sys;
   logic             ill;
   logic [`XLEN-1:0] imm_ext;

   assign op    = iq_inst[31:26];
   assign rs    = iq_inst[25:21];
   assign rt    = iq_inst[20:16];
   assign rd    = iq_inst[15:11];
   assign shamt = iq_inst[10:6];
   assign funct = iq_inst[5:0];
   assign imm   = iq_inst[15:0];

   // a stopping instruction in the hold slot already blocks the next one
   assign stop   = stopped_q | (iq_valid & (sys | ill));
   assign accept = inst_valid & ~stop;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         iq_valid  <= 1'b0;
         stopped_q <= 1'b0;
      end else begin
         iq_valid  <= accept;
         stopped_q <= stop;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         iq_inst <= inst;
      end
   end

   // opcode and funct to ALU op, operand source and destination
   always_comb begin
      alu_op   = ALU_ADD;
      src      = SRC_IMM;
      imm_kind = IMM_SIGN;
      dest     = rt;
      we       = 1'b1;
      sys      = 1'b0;
      ill      = 1'b0;
      case (op)
         OP_SPECIAL: begin
            // register forms write rd and take rt as second operand
            dest = rd;
            src  = SRC_RT;
            case (funct)
               FN_ADD:  alu_op = ALU_ADD;
               FN_ADDU: alu_op = ALU_ADDU;
               FN_SUB:  alu_op = ALU_SUB;
               FN_SUBU: alu_op = ALU_SUBU;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_SLL, FN_SRL, FN_SRA: begin
                  // shamt rides in the immediate slot
                  src      = SRC_IMM;
                  imm_kind = IMM_SHAMT;
                  alu_op   = (funct == FN_SLL) ? ALU_SLL :
                             (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
               end
               FN_SYSCALL: begin
                  we  = 1'b0;
                  sys = 1'b1;
               end
               default: begin
                  we  = 1'b0;
                  ill = 1'b1;
               end
            endcase
         end
         OP_ADDI:  alu_op = ALU_ADD;
         OP_ADDIU: alu_op = ALU_ADDU;
         OP_ANDI: begin
            alu_op   = ALU_AND;
            imm_kind = IMM_ZERO;
         end
         OP_ORI: begin
            alu_op   = ALU_OR;
            imm_kind = IMM_ZERO;
         end
         OP_XORI: begin
            alu_op   = ALU_XOR;
            imm_kind = IMM_ZERO;
         end
         // any other opcode is reserved
         default: begin
            we  = 1'b0;
            ill = 1'b1;
         end
      endcase
   end

   // immediate extension
   always_comb begin
      case (imm_kind)
         IMM_ZERO:  imm_ext = {{(`XLEN-$bits(imm16_t)){1'b0}}, imm};
         IMM_SHAMT: imm_ext = {{(`XLEN-$bits(shamt_t)){1'b0}}, shamt};
         default:   imm_ext = {{(`XLEN-$bits(imm16_t)){imm[15]}}, imm};
      endcase
   end

   // operand reads happen while the instruction sits in the hold slot
   assign rd_rs_addr = rs;
   assign rd_rt_addr = rt;

   // decode-to-execute register, control part
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         dx_valid <= 1'b0;
         dx_we    <= 1'b0;
         dx_sys   <= 1'b0;
         dx_ill   <= 1'b0;
      end else begin
         dx_valid <= iq_valid;
         dx_we    <= iq_valid & we;
         dx_sys   <= iq_valid & sys;
         dx_ill   <= iq_valid & ill;
      end
   end

   // decode-to-execute register, payload part
   always_ff @(posedge clk) begin
      dx_alu_op  <= alu_op;
      dx_src     <= src;
      dx_rs      <= rs;
      dx_rt      <= rt;
      dx_rs_data <= rd_rs_data;
      dx_rt_data <= rd_rt_data;
      dx_imm     <= imm_ext;
      dx_dest    <= dest;
   end

endmodule

/* reg_file.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module reg_file (
   input  logic                clk,
   input  logic                rst_b,
   // write port, driven from the retiring instruction
   input  logic                rf_we,
   input  isa_pkg::reg_addr_t  rf_addr,
   input  logic [`XLEN-1:0]    rf_data,
   // two read ports for decode
   input  isa_pkg::reg_addr_t  rd_rs_addr,
   input  isa_pkg::reg_addr_t  rd_rt_addr,
   output logic [`XLEN-1:0]    rd_rs_data,
   output logic [`XLEN-1:0]    rd_rt_data
);

   // register array, entry 0 never written
   logic [`XLEN-1:0] regs [`REG_COUNT];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (rf_we && (rf_addr != '0)) begin
         regs[rf_addr] <= rf_data;
      end
   end

   // r0 reads zero
   // a write in the same cycle bypasses the array, which covers the
   // instruction two ahead of the one being decoded
   assign rd_rs_data = (rd_rs_addr == '0)                 ? '0 :
                       (rf_we && (rf_addr == rd_rs_addr)) ? rf_data :
                                                            regs[rd_rs_addr];

   assign rd_rt_data = (rd_rt_addr == '0)                 ? '0 :
                       (rf_we && (rf_addr == rd_rt_addr)) ? rf_data :
                                                            regs[rd_rt_addr];

endmodule

/* pipe_pkg.sv */
package pipe_pkg;

   // operation carried from decode into the ALU
   // signed and unsigned pairs stay distinct so the decoded op keeps
   // the instruction identity, even though both wrap the same way
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_ADDU = 4'd1,
      ALU_SUB  = 4'd2,
      ALU_SUBU = 4'd3,
      ALU_AND  = 4'd4,
      ALU_OR   = 4'd5,
      ALU_XOR  = 4'd6,
      // shifts move the rt value, amount comes from the immediate slot
      ALU_SLL  = 4'd7,
      ALU_SRL  = 4'd8,
      ALU_SRA  = 4'd9
   } alu_op_e;

   // where the second ALU operand comes from
   typedef enum logic {
      SRC_RT  = 1'b0,
      SRC_IMM = 1'b1
   } op_src_e;

   // how decode builds the immediate slot
   // sign for addi/addiu, zero for logical immediates, shamt for shifts
   typedef enum logic [1:0] {
      IMM_SIGN  = 2'd0,
      IMM_ZERO  = 2'd1,
      IMM_SHAMT = 2'd2
   } imm_kind_e;

endpackage

/* isa_pkg.sv */
`include "core_settings.svh"

package isa_pkg;

   // instruction field types
   // opcode sits in bits 31:26, funct in 5:0
   typedef logic [5:0]             opcode_t;
   typedef logic [5:0]             funct_t;
   // rs 25:21, rt 20:16, rd 15:11
   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
   // shift amount in bits 10:6
   typedef logic [4:0]             shamt_t;
   // immediate in bits 15:0
   typedef logic [15:0]            imm16_t;

   // primary opcodes
   // all register-register forms share OP_SPECIAL and are told apart by funct
   localparam opcode_t OP_SPECIAL = 6'h00;
   localparam opcode_t OP_ADDI    = 6'h08;
   localparam opcode_t OP_ADDIU   = 6'h09;
   // logical immediates, zero extended
   localparam opcode_t OP_ANDI    = 6'h0c;
   localparam opcode_t OP_ORI     = 6'h0d;
   localparam opcode_t OP_XORI    = 6'h0e;

   // secondary opcodes under OP_SPECIAL
   // shifts by the constant shamt field
   localparam funct_t FN_SLL     = 6'h00;
   localparam funct_t FN_SRL     = 6'h02;
   localparam funct_t FN_SRA     = 6'h03;
   // stops the core
   localparam funct_t FN_SYSCALL = 6'h0c;
   // arithmetic
   localparam funct_t FN_ADD     = 6'h20;
   localparam funct_t FN_ADDU    = 6'h21;
   localparam funct_t FN_SUB     = 6'h22;
   localparam funct_t FN_SUBU    = 6'h23;
   // bitwise logic
   localparam funct_t FN_AND     = 6'h24;
   localparam funct_t FN_OR      = 6'h25;
   localparam funct_t FN_XOR     = 6'h26;

endpackage

/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath width of registers, operands and results
`define XLEN 32

// number of architectural registers, r0 included
`define REG_COUNT 32

// bits needed to name one register
`define REG_ADDR_W 5

`endif
